// File: dv/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 20 ns clock, reset held low for the first two cycles
 */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;  // Released off the edge like other inputs
  end

endmodule

// File: dv/tb_matrix_cps.sv
/*
 * Testbench for the matrix coprocessor front end
 * Table driven issue and commit, per-unit in-order result model
 */
`timescale 1ns/100ps
`include "matrix_cps_defines.svh"

module tb_matrix_cps;

  localparam int NUM_ROWS = 26;
  localparam int LIMIT    = 40 * NUM_ROWS + 200;  // Cycles before the run is cut off
  localparam int HOLD     = 100;                   // Cycles of result back-pressure

  typedef struct packed {
    matrix_cps_pkg::instr_t     instr;
    matrix_cps_pkg::instr_id_t  id;
    logic                       accept;
    matrix_cps_pkg::exec_unit_e unit;
  } stim_row_t;

  logic                       clk;
  logic                       rst_n;
  logic                       issue_valid;
  matrix_cps_pkg::instr_t     issue_instr;
  matrix_cps_pkg::instr_id_t  issue_id;
  logic                       x_issue_ready;
  logic                       x_issue_accept;
  logic                       commit_valid;
  matrix_cps_pkg::instr_id_t  commit_id;
  logic                       x_result_valid;
  logic                       result_ready;
  matrix_cps_pkg::instr_id_t  x_result_id;

  stim_row_t                  stim [NUM_ROWS];
  matrix_cps_pkg::instr_id_t  zero_q [$];  // Expected ids, tile zero
  matrix_cps_pkg::instr_id_t  copy_q [$];  // Expected ids, tile copy
  logic                       pending [1 << `MCPS_ID_WIDTH];
  matrix_cps_pkg::exec_unit_e unit_of [1 << `MCPS_ID_WIDTH];
  logic [7:0]                 lfsr;
  int                         errors, errors_mark, checks, tests, cycles;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  matrix_cps_top dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .x_issue_valid_i  (issue_valid),
    .x_issue_ready_o  (x_issue_ready),
    .x_issue_instr_i  (issue_instr),
    .x_issue_id_i     (issue_id),
    .x_issue_accept_o (x_issue_accept),
    .x_commit_valid_i (commit_valid),
    .x_commit_id_i    (commit_id),
    .x_result_valid_o (x_result_valid),
    .x_result_ready_i (result_ready),
    .x_result_id_o    (x_result_id)
  );

  // ****************************************
  // Helpers
  // ****************************************

  task automatic set_row(input int idx, input matrix_cps_pkg::instr_t instr,
                         input matrix_cps_pkg::instr_id_t id, input logic acc,
                         input matrix_cps_pkg::exec_unit_e unit);
    stim[idx] = '{instr, id, acc, unit};
  endtask

  task automatic load_stim();
    // Decode: opcode and funct3 mix
    set_row(0, 32'h0000_000B, 4'd1, 1'b1, matrix_cps_pkg::UNIT_ZERO);
    set_row(1, 32'h0000_100B, 4'd2, 1'b1, matrix_cps_pkg::UNIT_COPY);
    set_row(2, 32'h0000_0033, 4'd3, 1'b0, matrix_cps_pkg::UNIT_ZERO);  // R-type opcode
    set_row(3, 32'h0000_200B, 4'd4, 1'b0, matrix_cps_pkg::UNIT_ZERO);  // Unused funct3
    set_row(4, 32'h01A3_800B, 4'd5, 1'b1, matrix_cps_pkg::UNIT_ZERO);
    set_row(5, 32'h01A3_900B, 4'd6, 1'b1, matrix_cps_pkg::UNIT_COPY);
    set_row(6, 32'h0000_102B, 4'd7, 1'b0, matrix_cps_pkg::UNIT_ZERO);
    set_row(7, 32'h0000_700B, 4'd8, 1'b0, matrix_cps_pkg::UNIT_ZERO);
    // Commit gating
    set_row(8, 32'h0000_000B, 4'd9, 1'b1, matrix_cps_pkg::UNIT_ZERO);
    set_row(9, 32'h0000_100B, 4'd10, 1'b1, matrix_cps_pkg::UNIT_COPY);
    // Buffer full
    set_row(10, 32'h0000_000B, 4'd11, 1'b1, matrix_cps_pkg::UNIT_ZERO);
    set_row(11, 32'h0000_100B, 4'd12, 1'b1, matrix_cps_pkg::UNIT_COPY);
    set_row(12, 32'h0000_000B, 4'd13, 1'b1, matrix_cps_pkg::UNIT_ZERO);
    set_row(13, 32'h0000_000B, 4'd14, 1'b1, matrix_cps_pkg::UNIT_ZERO);
    // Back-pressure, twelve mixed
    for (int i = 0; i < 12; i++) begin
      set_row(14 + i, (12'h5A3 >> i) & 1 ? 32'h0000_100B : 32'h0000_000B,
              matrix_cps_pkg::instr_id_t'(i), 1'b1,
              (12'h5A3 >> i) & 1 ? matrix_cps_pkg::UNIT_COPY : matrix_cps_pkg::UNIT_ZERO);
    end
  endtask

  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // x^8+x^6+x^5+x^4+1
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      gap  = gap * 2 + int'(lfsr[0]);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input matrix_cps_pkg::instr_id_t got,
                          input matrix_cps_pkg::instr_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got id %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Called and returns 2 ns after a rising edge
  task automatic issue_row(input int idx);
    issue_valid = 1'b1;
    issue_instr = stim[idx].instr;
    issue_id    = stim[idx].id;
    @(negedge clk);
    while (!x_issue_ready) @(negedge clk);
    check_flag(x_issue_accept, stim[idx].accept, $sformatf("accept of row %0d", idx));
    @(posedge clk);
    #2;
    issue_valid = 1'b0;
    if (stim[idx].accept) begin
      pending[stim[idx].id] = 1'b1;
      unit_of[stim[idx].id] = stim[idx].unit;
      if (stim[idx].unit == matrix_cps_pkg::UNIT_COPY) copy_q.push_back(stim[idx].id);
      else zero_q.push_back(stim[idx].id);
    end
  endtask

  task automatic commit(input matrix_cps_pkg::instr_id_t id);
    commit_valid = 1'b1;
    commit_id    = id;
    @(posedge clk);
    #2;
    commit_valid = 1'b0;
  endtask

  task automatic run_row(input int idx, input bit do_commit);
    int gap;
    draw_gap(gap);
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    issue_row(idx);
    if (do_commit && stim[idx].accept) commit(stim[idx].id);
  endtask

  // Wait for every expected id, then look for strays
  task automatic wait_drain();
    while (zero_q.size() != 0 || copy_q.size() != 0) @(posedge clk);
    repeat (12) @(posedge clk);
    @(negedge clk);
    check_flag(x_result_valid, 1'b0, "stray result after drain");
    @(posedge clk);
    #2;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_mark);
    errors_mark = errors;
  endtask

  // ****************************************
  // Result monitor and timeout
  // ****************************************

  always @(negedge clk) begin
    matrix_cps_pkg::instr_id_t got;
    matrix_cps_pkg::instr_id_t exp;
    if (rst_n && x_result_valid && result_ready) begin
      got = x_result_id;
      if (!pending[got]) begin
        errors++;
        $display("error at %0t: result id %0d was not outstanding", $time, got);
      end else begin
        if (unit_of[got] == matrix_cps_pkg::UNIT_COPY) exp = copy_q.pop_front();
        else exp = zero_q.pop_front();
        pending[got] = 1'b0;
        check_id(got, exp, "result order within unit");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    int waited;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_id     = '0;
    commit_valid = 1'b0;
    commit_id    = '0;
    result_ready = 1'b1;
    lfsr         = 8'd6;
    errors       = 0;
    errors_mark  = 0;
    checks       = 0;
    tests        = 0;
    cycles       = 0;
    for (int i = 0; i < (1 << `MCPS_ID_WIDTH); i++) pending[i] = 1'b0;
    load_stim();

    wait (rst_n === 1'b1);
    @(negedge clk);
    check_flag(x_result_valid, 1'b0, "result valid after reset");
    check_flag(x_issue_ready, 1'b1, "issue ready after reset");
    @(posedge clk);
    #2;
    end_test("reset");

    for (int i = 0; i < 8; i++) run_row(i, 1'b1);
    wait_drain();
    end_test("accept decode");

    run_row(8, 1'b0);
    run_row(9, 1'b0);
    repeat (30) begin
      @(negedge clk);
      check_flag(x_result_valid, 1'b0, "result before commit");
    end
    @(posedge clk);
    #2;
    commit(stim[8].id);
    commit(stim[9].id);
    wait_drain();
    end_test("commit gating");

    for (int i = 0; i < `MCPS_IN_BUF_DEPTH; i++) run_row(10 + i, 1'b0);
    @(negedge clk);
    check_flag(x_issue_ready, 1'b0, "issue ready with full buffer");
    @(posedge clk);
    #2;
    commit(stim[10].id);
    waited = 0;
    while (!x_issue_ready && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    check_flag(x_issue_ready, 1'b1, "issue ready after a commit");
    @(posedge clk);
    #2;
    for (int i = 1; i < `MCPS_IN_BUF_DEPTH; i++) commit(stim[10 + i].id);
    wait_drain();
    end_test("buffer full");

    result_ready = 1'b0;
    fork
      begin
        for (int i = 14; i < NUM_ROWS; i++) run_row(i, 1'b1);
      end
      begin
        repeat (HOLD) @(negedge clk);
        check_flag(x_result_valid, 1'b1, "results held under back-pressure");
        @(posedge clk);
        #2;
        result_ready = 1'b1;
      end
    join
    wait_drain();
    end_test("result back-pressure");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

endmodule

// File: include/matrix_cps_defines.svh
/*
 * Matrix coprocessor front end constants
 * Widths, buffer depths, the accepted encoding and per-unit row counts
 */
`ifndef MATRIX_CPS_DEFINES_SVH
`define MATRIX_CPS_DEFINES_SVH

// Widths and depths
`define MCPS_ID_WIDTH        4
`define MCPS_IN_BUF_DEPTH    4
`define MCPS_RES_FIFO_DEPTH  8

// Instruction encoding
`define MCPS_OPCODE          7'b0001011  // custom-0
`define MCPS_FUNCT_ZERO      3'b000      // Tile zero
`define MCPS_FUNCT_COPY      3'b001      // Tile copy

// Rows stepped by each unit
`define MCPS_ZERO_ROWS       4
`define MCPS_COPY_ROWS       8

`endif

// File: matrix_cps.f
+incdir+include
src/matrix_cps_pkg.sv
src/matrix_cps_if.sv
src/matrix_cps_row_engine.sv
src/matrix_cps_dispatcher.sv
src/matrix_cps_issue_stage.sv
src/matrix_cps_result_stage.sv
src/matrix_cps_top.sv
dv/tb_clock_gen.sv
dv/tb_matrix_cps.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the matrix coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f matrix_cps.f \
  --top-module tb_matrix_cps -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/Vtb_matrix_cps" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: src/matrix_cps_dispatcher.sv
/*
 * Dispatcher
 * Routes the committed head instruction to the tile zero or tile copy
 * row engine, holding it while the target is busy or results are near full
 */
`timescale 1ns/100ps
`include "matrix_cps_defines.svh"

module matrix_cps_dispatcher (
  input  logic         clk_i,
  input  logic         rst_ni,
  instr_stream_if.sink head,
  input  logic         res_almost_full_i,
  finish_if.source     zero_fin,
  finish_if.source     copy_fin
);

  logic zero_idle;
  logic copy_idle;
  logic sel_idle;
  logic xfer;
  logic zero_start;
  logic copy_start;

  // Only the targeted engine can block the head
  assign sel_idle   = (head.unit == matrix_cps_pkg::UNIT_COPY) ? copy_idle : zero_idle;
  assign head.ready = sel_idle && !res_almost_full_i;
  assign xfer       = head.valid && head.ready;

  assign zero_start = xfer && (head.unit == matrix_cps_pkg::UNIT_ZERO);
  assign copy_start = xfer && (head.unit == matrix_cps_pkg::UNIT_COPY);

  // ****************************************
  // Execution units
  // ****************************************

  matrix_cps_row_engine #(
    .ROWS (`MCPS_ZERO_ROWS)
  ) u_zero_engine (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (zero_start),
    .id_i    (head.id),
    .idle_o  (zero_idle),
    .fin     (zero_fin)
  );

  matrix_cps_row_engine #(
    .ROWS (`MCPS_COPY_ROWS)
  ) u_copy_engine (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (copy_start),
    .id_i    (head.id),
    .idle_o  (copy_idle),
    .fin     (copy_fin)
  );

  // At most one engine leaves idle in a cycle
  a_one_start : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !($fell(zero_idle) && $fell(copy_idle)));

  // A stalled head must hold its payload until taken
  a_head_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    head.valid && !head.ready |=> head.valid && $stable(head.id) && $stable(head.unit));

endmodule

// File: src/matrix_cps_if.sv
/*
 * Internal handshake bundles
 * instr_stream_if carries committed instructions to dispatch,
 * finish_if carries a finished id from a unit to the result stage
 */
`timescale 1ns/100ps

interface instr_stream_if;
  logic                      valid;
  logic                      ready;
  matrix_cps_pkg::instr_id_t id;
  matrix_cps_pkg::exec_unit_e unit;

  modport source (
    output valid,
    output id,
    output unit,
    input  ready
  );

  modport sink (
    input  valid,
    input  id,
    input  unit,
    output ready
  );
endinterface

interface finish_if;
  logic                      finished;  // Held until ack
  logic                      ack;       // One-cycle pulse
  matrix_cps_pkg::instr_id_t id;

  modport source (
    output finished,
    output id,
    input  ack
  );

  modport sink (
    input  finished,
    input  id,
    output ack
  );
endinterface

// File: src/matrix_cps_issue_stage.sv
/*
 * Issue stage
 * Decodes offered instructions, buffers accepted ones in order and
 * releases the head only once the CPU has committed it
 */
`timescale 1ns/100ps
`include "matrix_cps_defines.svh"

module matrix_cps_issue_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      issue_valid_i,
  input  matrix_cps_pkg::instr_t    issue_instr_i,
  input  matrix_cps_pkg::instr_id_t issue_id_i,
  output logic                      issue_ready_o,
  output logic                      issue_accept_o,
  input  logic                      commit_valid_i,
  input  matrix_cps_pkg::instr_id_t commit_id_i,
  instr_stream_if.source            head
);

  localparam int unsigned DEPTH = `MCPS_IN_BUF_DEPTH;
  localparam int unsigned AW    = $clog2(DEPTH);

  logic [2:0]                 funct3;
  matrix_cps_pkg::exec_unit_e dec_unit;
  logic                       push;
  logic                       pop;
  logic                       full;
  logic                       commit_ok;

  logic [AW-1:0]              wr_ptr_q, rd_ptr_q;
  matrix_cps_pkg::buf_cnt_t   count_q;
  matrix_cps_pkg::buf_cnt_t   uncommit_q;  // Accepted but not yet committed
  matrix_cps_pkg::instr_id_t  last_commit_q;
  logic                       last_commit_vld_q;

  matrix_cps_pkg::instr_id_t  id_mem_q [DEPTH];
  matrix_cps_pkg::exec_unit_e unit_mem_q [DEPTH];

  // ****************************************
  // Accept decode
  // ****************************************

  assign funct3   = issue_instr_i[14:12];
  assign dec_unit = (funct3 == `MCPS_FUNCT_COPY) ? matrix_cps_pkg::UNIT_COPY
                                                 : matrix_cps_pkg::UNIT_ZERO;

  assign issue_accept_o = (issue_instr_i[6:0] == `MCPS_OPCODE) &&
                          ((funct3 == `MCPS_FUNCT_ZERO) || (funct3 == `MCPS_FUNCT_COPY));

  // ****************************************
  // Input buffer, fall-through
  // ****************************************

  assign full          = (count_q == matrix_cps_pkg::buf_cnt_t'(DEPTH));
  assign issue_ready_o = !full;
  assign push          = issue_valid_i && issue_ready_o && issue_accept_o;  // Rejects dropped
  assign pop           = head.valid && head.ready;

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem_q[wr_ptr_q]   <= issue_id_i;
      unit_mem_q[wr_ptr_q] <= dec_unit;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // ****************************************
  // Commit gating
  // ****************************************

  // A commit repeating the previous id is dropped
  assign commit_ok = commit_valid_i && (!last_commit_vld_q || (commit_id_i != last_commit_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      uncommit_q        <= '0;
      last_commit_q     <= '0;
      last_commit_vld_q <= 1'b0;
    end else begin
      if (commit_ok) begin
        last_commit_q     <= commit_id_i;
        last_commit_vld_q <= 1'b1;
      end
      case ({push, commit_ok})
        2'b10:   uncommit_q <= uncommit_q + 1'b1;
        2'b01:   uncommit_q <= uncommit_q - 1'b1;
        default: uncommit_q <= uncommit_q;  // Both or neither
      endcase
    end
  end

  // More entries than uncommitted ones means the head is committed
  assign head.valid = (uncommit_q < count_q);
  assign head.id    = id_mem_q[rd_ptr_q];
  assign head.unit  = unit_mem_q[rd_ptr_q];

  a_count_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= matrix_cps_pkg::buf_cnt_t'(DEPTH));
  a_uncommit_le_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
    uncommit_q <= count_q);

endmodule

// File: src/matrix_cps_pkg.sv
/*
 * Matrix coprocessor shared types
 * Instruction word, id, unit select and engine state
 */
`include "matrix_cps_defines.svh"

package matrix_cps_pkg;

  // ****************************************
  // Payload types
  // ****************************************

  typedef logic [31:0] instr_t;
  typedef logic [`MCPS_ID_WIDTH-1:0] instr_id_t;

  typedef logic [3:0] row_cnt_t;  // Up to 16 rows per unit
  typedef logic [2:0] buf_cnt_t;  // Input buffer occupancy

  // ****************************************
  // Enumerations
  // ****************************************

  typedef enum logic {
    UNIT_ZERO = 1'b0,
    UNIT_COPY = 1'b1
  } exec_unit_e;

  typedef enum logic [1:0] {
    ENG_IDLE = 2'd0,
    ENG_BUSY = 2'd1,
    ENG_DONE = 2'd2  // Waiting for result ack
  } engine_state_e;

endpackage

// File: src/matrix_cps_result_stage.sv
/*
 * Result stage
 * Fixed-priority grant over finished units into a result id FIFO
 * that the CPU drains with valid/ready
 */
`timescale 1ns/100ps
`include "matrix_cps_defines.svh"

module matrix_cps_result_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  finish_if.sink                    zero_fin,
  finish_if.sink                    copy_fin,
  output logic                      almost_full_o,
  output logic                      result_valid_o,
  input  logic                      result_ready_i,
  output matrix_cps_pkg::instr_id_t result_id_o
);

  localparam int unsigned DEPTH = `MCPS_RES_FIFO_DEPTH;
  localparam int unsigned AW    = $clog2(DEPTH);

  typedef logic [AW:0]   usage_t;
  typedef logic [AW-1:0] ptr_t;

  logic                      full;
  logic                      empty;
  logic                      grant_zero;
  logic                      grant_copy;
  logic                      push;
  logic                      pop;
  matrix_cps_pkg::instr_id_t push_id;

  usage_t                    usage_q;
  ptr_t                      wr_ptr_q, rd_ptr_q;
  matrix_cps_pkg::instr_id_t mem_q [DEPTH];

  // ****************************************
  // Arbiter, zero before copy
  // ****************************************

  assign grant_zero = zero_fin.finished && !full;
  assign grant_copy = copy_fin.finished && !zero_fin.finished && !full;

  assign zero_fin.ack = grant_zero;
  assign copy_fin.ack = grant_copy;

  assign push    = grant_zero || grant_copy;
  assign push_id = grant_zero ? zero_fin.id : copy_fin.id;

  // ****************************************
  // Result FIFO
  // ****************************************

  assign full          = (usage_q == usage_t'(DEPTH));
  assign empty         = (usage_q == '0);
  assign almost_full_o = (usage_q > usage_t'(DEPTH - 2));  // Under two free slots
  assign pop           = !empty && result_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_id;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usage_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop && !push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Registered head, a new id shows one cycle after push
  assign result_valid_o = !empty;
  assign result_id_o    = mem_q[rd_ptr_q];

  a_usage_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    usage_q <= usage_t'(DEPTH));

  // The acked unit must drop finished straight away
  a_zero_ack_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    zero_fin.ack |=> !zero_fin.ack);

endmodule

// File: src/matrix_cps_row_engine.sv
/*
 * Row engine
 * Steps through ROWS rows after a start, then holds finished until ack
 */
`timescale 1ns/100ps

module matrix_cps_row_engine #(
  parameter int unsigned ROWS = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  matrix_cps_pkg::instr_id_t id_i,
  output logic                      idle_o,
  finish_if.source                  fin
);

  matrix_cps_pkg::engine_state_e state_q;
  matrix_cps_pkg::row_cnt_t      row_q;  // Rows left minus one
  matrix_cps_pkg::instr_id_t     id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= matrix_cps_pkg::ENG_IDLE;
      row_q   <= '0;
    end else begin
      case (state_q)
        matrix_cps_pkg::ENG_IDLE: begin
          if (start_i) begin
            state_q <= matrix_cps_pkg::ENG_BUSY;
            row_q   <= matrix_cps_pkg::row_cnt_t'(ROWS - 1);
          end
        end
        matrix_cps_pkg::ENG_BUSY: begin
          if (row_q == '0) state_q <= matrix_cps_pkg::ENG_DONE;  // Last row
          else row_q <= row_q - 1'b1;
        end
        matrix_cps_pkg::ENG_DONE: begin
          if (fin.ack) state_q <= matrix_cps_pkg::ENG_IDLE;
        end
        default: state_q <= matrix_cps_pkg::ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) id_q <= id_i;
  end

  assign idle_o       = (state_q == matrix_cps_pkg::ENG_IDLE);
  assign fin.finished = (state_q == matrix_cps_pkg::ENG_DONE);
  assign fin.id       = id_q;

  a_start_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> state_q == matrix_cps_pkg::ENG_IDLE);
  a_ack_finished : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fin.ack |-> state_q == matrix_cps_pkg::ENG_DONE);

endmodule

// File: src/matrix_cps_top.sv
/*
 * Matrix coprocessor front end top level
 * Issue, dispatch and result stages behind the offload ports
 */
`timescale 1ns/100ps

module matrix_cps_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Issue
  input  logic                      x_issue_valid_i,
  output logic                      x_issue_ready_o,
  input  matrix_cps_pkg::instr_t    x_issue_instr_i,
  input  matrix_cps_pkg::instr_id_t x_issue_id_i,
  output logic                      x_issue_accept_o,

  // Commit
  input  logic                      x_commit_valid_i,
  input  matrix_cps_pkg::instr_id_t x_commit_id_i,

  // Result
  output logic                      x_result_valid_o,
  input  logic                      x_result_ready_i,
  output matrix_cps_pkg::instr_id_t x_result_id_o
);

  logic res_almost_full;

  instr_stream_if head_if ();
  finish_if       zero_fin_if ();
  finish_if       copy_fin_if ();

  matrix_cps_issue_stage u_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (x_issue_valid_i),
    .issue_instr_i  (x_issue_instr_i),
    .issue_id_i     (x_issue_id_i),
    .issue_ready_o  (x_issue_ready_o),
    .issue_accept_o (x_issue_accept_o),
    .commit_valid_i (x_commit_valid_i),
    .commit_id_i    (x_commit_id_i),
    .head           (head_if)
  );

  matrix_cps_dispatcher u_dispatch (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .head              (head_if),
    .res_almost_full_i (res_almost_full),
    .zero_fin          (zero_fin_if),
    .copy_fin          (copy_fin_if)
  );

  matrix_cps_result_stage u_result (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .zero_fin       (zero_fin_if),
    .copy_fin       (copy_fin_if),
    .almost_full_o  (res_almost_full),
    .result_valid_o (x_result_valid_o),
    .result_ready_i (x_result_ready_i),
    .result_id_o    (x_result_id_o)
  );

endmodule
